//--- boot_pkg.sv
package boot_pkg;

   // ****************************************
   // Data path sizes
   // ****************************************

   parameter int unsigned DATA_W = 32;          // ICCM word width
   parameter int unsigned BYTES_PER_WORD = 4;   // Serial bytes per ICCM word

   // Last word of a program image, never stored
   parameter logic [DATA_W-1:0] END_MARKER = 32'h0000_0FFF;

   // ****************************************
   // State and response encodings
   // ****************************************

   // Serial receiver FSM
   typedef enum logic [1:0] {
      IDLE  = 2'd0,   // Line idle, waiting for falling edge
      START = 2'd1,   // Checking start bit at mid period
      DATA  = 2'd2,   // Sampling eight data bits
      STOP  = 2'd3    // Sampling stop bit
   } uart_state_e;

   // AXI read response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_e;

   // AXI4-Lite read slave FSM
   typedef enum logic [1:0] {
      AR_IDLE = 2'd0,   // Address channel open
      RD_MEM  = 2'd1,   // RAM read in progress
      R_VALID = 2'd2    // Response presented on R
   } axi_rd_state_e;

endpackage

//--- uart_rx.sv
module uart_rx (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        serial_i,
   input  logic [15:0] clks_per_bit_i,   // Clocks per serial bit
   output logic        rx_valid_o,
   output logic [7:0]  rx_byte_o
);

   boot_pkg::uart_state_e state_q;

   logic        rx_meta_q;
   logic        rx_sync_q;
   logic        rx_prev_q;
   logic [15:0] cnt_q;
   logic [2:0]  bit_idx_q;
   logic [7:0]  shift_q;
   logic        valid_q;
   logic        fall_edge;
   logic [15:0] half_bit;
   logic        bit_done;

   assign fall_edge = rx_prev_q & ~rx_sync_q;              // Start of a frame
   assign half_bit  = {1'b0, clks_per_bit_i[15:1]};
   assign bit_done  = (cnt_q == clks_per_bit_i - 16'd1);   // One full bit period elapsed

   // ****************************************
   // Input synchronizer
   // ****************************************

   // Line idles high, so the flops come out of reset at 1
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         rx_meta_q <= 1'b1;
         rx_sync_q <= 1'b1;
         rx_prev_q <= 1'b1;
      end else begin
         rx_meta_q <= serial_i;
         rx_sync_q <= rx_meta_q;
         rx_prev_q <= rx_sync_q;
      end
   end

   // ****************************************
   // Frame FSM
   // ****************************************

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q   <= boot_pkg::IDLE;
         cnt_q     <= '0;
         bit_idx_q <= '0;
         valid_q   <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         case (state_q)
            boot_pkg::IDLE: begin
               cnt_q <= '0;
               if (fall_edge) begin
                  state_q <= boot_pkg::START;
               end
            end
            boot_pkg::START: begin
               if (cnt_q == half_bit - 16'd1) begin
                  cnt_q     <= '0;
                  bit_idx_q <= '0;
                  // Glitch if line went back high
                  state_q   <= rx_sync_q ? boot_pkg::IDLE : boot_pkg::DATA;
               end else begin
                  cnt_q <= cnt_q + 16'd1;
               end
            end
            boot_pkg::DATA: begin
               if (bit_done) begin
                  cnt_q     <= '0;
                  bit_idx_q <= bit_idx_q + 3'd1;
                  if (bit_idx_q == 3'd7) begin
                     state_q <= boot_pkg::STOP;
                  end
               end else begin
                  cnt_q <= cnt_q + 16'd1;
               end
            end
            boot_pkg::STOP: begin
               if (bit_done) begin
                  valid_q <= rx_sync_q;   // Bad stop bit drops the byte
                  state_q <= boot_pkg::IDLE;
               end else begin
                  cnt_q <= cnt_q + 16'd1;
               end
            end
            default: state_q <= boot_pkg::IDLE;
         endcase
      end
   end

   // LSB arrives first, shift in from the top
   always_ff @(posedge clk) begin
      if ((state_q == boot_pkg::DATA) && bit_done) begin
         shift_q <= {rx_sync_q, shift_q[7:1]};
      end
   end

   assign rx_valid_o = valid_q;
   assign rx_byte_o  = shift_q;

   // Frames are far longer than one cycle
   a_valid_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      rx_valid_o |=> !rx_valid_o);

endmodule

//--- iccm_loader.sv
module iccm_loader #(
   parameter  int unsigned ICCM_DEPTH = 1024,
   localparam int unsigned ADDR_W     = $clog2(ICCM_DEPTH)
) (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  logic                        rx_valid_i,
   input  logic [7:0]                  rx_byte_i,
   output logic                        wr_en_o,
   output logic [ADDR_W-1:0]           wr_addr_o,
   output logic [boot_pkg::DATA_W-1:0] wr_data_o,
   output logic                        core_hold_o
);

   localparam int unsigned CNT_W = $clog2(boot_pkg::BYTES_PER_WORD);

   logic [CNT_W-1:0]            byte_cnt_q;
   logic [boot_pkg::DATA_W-1:0] word_q;
   logic [boot_pkg::DATA_W-1:0] word_next;
   logic [boot_pkg::DATA_W-1:0] wr_data_q;
   logic [ADDR_W-1:0]           addr_q;
   logic                        wr_en_q;
   logic                        hold_q;
   logic                        full_q;
   logic                        byte_take;
   logic                        last_byte;

   // ****************************************
   // Byte packing
   // ****************************************

   // New byte enters at the top, so the first one ends up in bits 7:0
   assign word_next = {rx_byte_i, word_q[boot_pkg::DATA_W-1:8]};

   assign byte_take = rx_valid_i & hold_q;   // Nothing accepted once released
   assign last_byte = byte_take &&
                      (byte_cnt_q == CNT_W'(boot_pkg::BYTES_PER_WORD - 1));

   always_ff @(posedge clk) begin
      if (byte_take) begin
         word_q <= word_next;
      end
      if (last_byte) begin
         wr_data_q <= word_next;
      end
   end

   // ****************************************
   // Write sequencing and core hold
   // ****************************************

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         byte_cnt_q <= '0;
         addr_q     <= '0;
         wr_en_q    <= 1'b0;
         hold_q     <= 1'b1;
         full_q     <= 1'b0;
      end else begin
         wr_en_q <= 1'b0;

         if (last_byte) begin
            byte_cnt_q <= '0;
         end else if (byte_take) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
         end

         if (last_byte) begin
            if (word_next == boot_pkg::END_MARKER) begin
               hold_q <= 1'b0;          // Program complete, let the core run
            end else if (!full_q) begin
               wr_en_q <= 1'b1;
            end
         end

         // Step the address after each write, stick at the last word
         if (wr_en_q) begin
            if (addr_q == ADDR_W'(ICCM_DEPTH - 1)) begin
               full_q <= 1'b1;
            end else begin
               addr_q <= addr_q + 1'b1;
            end
         end
      end
   end

   assign wr_en_o     = wr_en_q;
   assign wr_addr_o   = addr_q;
   assign wr_data_o   = wr_data_q;
   assign core_hold_o = hold_q;

   // The ICCM belongs to the fetch side once the hold is dropped
   a_no_write_after_release: assert property (@(posedge clk) disable iff (!rst_n_i)
      wr_en_o |-> core_hold_o);

endmodule

//--- iccm_ram.sv
module iccm_ram #(
   parameter  int unsigned ICCM_DEPTH = 1024,
   localparam int unsigned ADDR_W     = $clog2(ICCM_DEPTH)
) (
   input  logic                        clk,

   // Write port, loader side
   input  logic                        wr_en_i,
   input  logic [ADDR_W-1:0]           wr_addr_i,
   input  logic [boot_pkg::DATA_W-1:0] wr_data_i,

   // Read port, fetch side
   input  logic                        rd_en_i,
   input  logic [ADDR_W-1:0]           rd_addr_i,
   output logic [boot_pkg::DATA_W-1:0] rd_data_o
);

   // ****************************************
   // Storage array
   // ****************************************

   logic [boot_pkg::DATA_W-1:0] mem [ICCM_DEPTH];
   logic [boot_pkg::DATA_W-1:0] rd_data_q;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // Output register keeps its value while rd_en_i is low
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data_q;   // Valid one cycle after rd_en_i

endmodule

//--- iccm_axil_rd.sv
module iccm_axil_rd #(
   parameter  int unsigned ICCM_DEPTH = 1024,
   localparam int unsigned ADDR_W     = $clog2(ICCM_DEPTH)
) (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  logic                        core_hold_i,

   // AR channel
   input  logic                        s_axil_arvalid_i,
   output logic                        s_axil_arready_o,
   input  logic [31:0]                 s_axil_araddr_i,

   // R channel
   output logic                        s_axil_rvalid_o,
   input  logic                        s_axil_rready_i,
   output logic [boot_pkg::DATA_W-1:0] s_axil_rdata_o,
   output boot_pkg::axi_resp_e         s_axil_rresp_o,

   // ICCM read port
   output logic                        rd_en_o,
   output logic [ADDR_W-1:0]           rd_addr_o,
   input  logic [boot_pkg::DATA_W-1:0] rd_data_i
);

   boot_pkg::axi_rd_state_e state_q;
   boot_pkg::axi_resp_e     resp_q;

   logic [ADDR_W-1:0] addr_q;
   logic [29:0]       ar_idx;
   logic              ar_hs;
   logic              ar_err;

   assign ar_idx = s_axil_araddr_i[31:2];   // Byte address to word index
   assign ar_hs  = s_axil_arvalid_i & s_axil_arready_o;
   assign ar_err = core_hold_i || (ar_idx >= 30'(ICCM_DEPTH));

   // Word index and response code of the accepted request
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         addr_q <= ar_idx[ADDR_W-1:0];
         resp_q <= ar_err ? boot_pkg::SLVERR : boot_pkg::OKAY;
      end
   end

   // ****************************************
   // One read in flight at a time
   // ****************************************

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= boot_pkg::AR_IDLE;
      end else begin
         case (state_q)
            boot_pkg::AR_IDLE: if (ar_hs)           state_q <= boot_pkg::RD_MEM;
            boot_pkg::RD_MEM:                       state_q <= boot_pkg::R_VALID;
            boot_pkg::R_VALID: if (s_axil_rready_i) state_q <= boot_pkg::AR_IDLE;
            default:                                state_q <= boot_pkg::AR_IDLE;
         endcase
      end
   end

   // RAM is only touched for a good request
   assign rd_en_o   = (state_q == boot_pkg::RD_MEM) && (resp_q == boot_pkg::OKAY);
   assign rd_addr_o = addr_q;

   assign s_axil_arready_o = (state_q == boot_pkg::AR_IDLE);
   assign s_axil_rvalid_o  = (state_q == boot_pkg::R_VALID);
   // RAM output register holds while waiting on rready
   assign s_axil_rdata_o   = (resp_q == boot_pkg::OKAY) ? rd_data_i : '0;
   assign s_axil_rresp_o   = resp_q;

   // R payload must hold under back-pressure
   a_r_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      (s_axil_rvalid_o && !s_axil_rready_i) |=>
      (s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o)));

endmodule

//--- boot_top.sv
module boot_top #(
   parameter  int unsigned ICCM_DEPTH = 1024,
   localparam int unsigned ADDR_W     = $clog2(ICCM_DEPTH)
) (
   input  logic                        clk,
   input  logic                        rst_n_i,

   // Program load
   input  logic                        uart_rx_i,
   input  logic [15:0]                 clks_per_bit_i,
   output logic                        core_hold_o,

   // AXI4-Lite read port
   input  logic                        s_axil_arvalid_i,
   output logic                        s_axil_arready_o,
   input  logic [31:0]                 s_axil_araddr_i,
   output logic                        s_axil_rvalid_o,
   input  logic                        s_axil_rready_i,
   output logic [boot_pkg::DATA_W-1:0] s_axil_rdata_o,
   output boot_pkg::axi_resp_e         s_axil_rresp_o
);

   // ****************************************
   // Internal nets
   // ****************************************

   logic                        rx_valid;
   logic [7:0]                  rx_byte;
   logic                        wr_en;
   logic [ADDR_W-1:0]           wr_addr;
   logic [boot_pkg::DATA_W-1:0] wr_data;
   logic                        rd_en;
   logic [ADDR_W-1:0]           rd_addr;
   logic [boot_pkg::DATA_W-1:0] rd_data;

   // Serial byte receiver
   uart_rx u_uart_rx (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .serial_i       (uart_rx_i),
      .clks_per_bit_i (clks_per_bit_i),
      .rx_valid_o     (rx_valid),
      .rx_byte_o      (rx_byte)
   );

   // Word packer and core hold
   iccm_loader #(.ICCM_DEPTH(ICCM_DEPTH)) u_loader (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rx_valid_i  (rx_valid),
      .rx_byte_i   (rx_byte),
      .wr_en_o     (wr_en),
      .wr_addr_o   (wr_addr),
      .wr_data_o   (wr_data),
      .core_hold_o (core_hold_o)
   );

   iccm_ram #(.ICCM_DEPTH(ICCM_DEPTH)) u_iccm (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   // Stands in for the fetch side of the core
   iccm_axil_rd #(.ICCM_DEPTH(ICCM_DEPTH)) u_axil_rd (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .core_hold_i      (core_hold_o),
      .s_axil_arvalid_i (s_axil_arvalid_i),
      .s_axil_arready_o (s_axil_arready_o),
      .s_axil_araddr_i  (s_axil_araddr_i),
      .s_axil_rvalid_o  (s_axil_rvalid_o),
      .s_axil_rready_i  (s_axil_rready_i),
      .s_axil_rdata_o   (s_axil_rdata_o),
      .s_axil_rresp_o   (s_axil_rresp_o),
      .rd_en_o          (rd_en),
      .rd_addr_o        (rd_addr),
      .rd_data_i        (rd_data)
   );

endmodule

//--- tb_boot_tasks.svh
`ifndef TB_BOOT_TASKS_SVH
`define TB_BOOT_TASKS_SVH

// ****************************************
// Bookkeeping
// ****************************************

task automatic begin_test(input string name);
   cur_test = name;
   test_err = 0;
endtask

task automatic end_test();
   if (test_err == 0) begin
      pass_cnt++;
      $display("%s passed", cur_test);
   end else begin
      fail_cnt++;
      $display("%s failed with %0d errors", cur_test, test_err);
   end
endtask

task automatic note_mismatch(input logic [31:0] exp, input logic [31:0] act);
   $display("ERR %s: expected %h, actual %h", cur_test, exp, act);
   test_err++;
endtask

task automatic abort_run(input string what);
   $display("Timeout in %s while waiting for %s", cur_test, what);
   $display("TEST RESULT: FAIL");
   $finish;
endtask

// ****************************************
// AXI4-Lite read helpers
// ****************************************

// Returns at the falling edge where rvalid is first seen high
task automatic issue_ar(input logic [31:0] addr, output int lat);
   int n;
   @(negedge clk);
   s_axil_arvalid_i = 1'b1;
   s_axil_araddr_i  = addr;
   n = 0;
   while (!s_axil_arready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
         abort_run("arready");
   end
   @(negedge clk);   // AR transfer on the rising edge just passed
   s_axil_arvalid_i = 1'b0;
   lat = 1;
   while (!s_axil_rvalid_o) begin
      @(negedge clk);
      lat++;
      if (lat > TIMEOUT)
         abort_run("rvalid");
   end
endtask

task automatic take_r();
   s_axil_rready_i = 1'b1;
   @(negedge clk);
   s_axil_rready_i = 1'b0;
endtask

// ****************************************
// Directed tests
// ****************************************

task automatic test_reset_state();
   begin_test("reset_state");
   @(negedge clk);
   if (core_hold_o !== 1'b1)
      note_mismatch(1, core_hold_o);
   if (s_axil_rvalid_o !== 1'b0)
      note_mismatch(0, s_axil_rvalid_o);
   if (s_axil_arready_o !== 1'b1)
      note_mismatch(1, s_axil_arready_o);
   end_test();
endtask

task automatic test_read_while_loading();
   int lat;
   begin_test("read_while_loading");
   issue_ar(32'h0, lat);
   if (s_axil_rresp_o !== boot_pkg::SLVERR)
      note_mismatch(boot_pkg::SLVERR, s_axil_rresp_o);
   if (s_axil_rdata_o !== '0)
      note_mismatch(0, s_axil_rdata_o);
   take_r();
   end_test();
endtask

task automatic test_load_program();
   logic [31:0] marker;
   int          n;
   begin_test("load_program");
   marker = boot_pkg::END_MARKER;
   for (int w = 0; w < 5; w++)
      words[w] = $random(seed);
   for (int w = 0; w < 5; w++) begin
      for (int b = 0; b < 4; b++) begin
         if (w == 2 && b == 2)
            send_byte(8'($random(seed)), 1'b1);   // Receiver must drop this one
         send_byte(words[w][8*b +: 8], 1'b0);
      end
   end
   if (core_hold_o !== 1'b1)
      note_mismatch(1, core_hold_o);   // Released before the marker
   for (int b = 0; b < 4; b++)
      send_byte(marker[8*b +: 8], 1'b0);
   n = 0;
   while (core_hold_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
         abort_run("core_hold_o to fall after the end marker");
   end
   end_test();
endtask

task automatic test_read_back();
   int lat;
   begin_test("read_back");
   for (int i = 0; i < 5; i++) begin
      issue_ar(32'(4 * i), lat);
      if (lat != 2)
         note_mismatch(2, lat);
      if (s_axil_rresp_o !== boot_pkg::OKAY)
         note_mismatch(boot_pkg::OKAY, s_axil_rresp_o);
      if (s_axil_rdata_o !== words[i])
         note_mismatch(words[i], s_axil_rdata_o);
      take_r();
   end
   end_test();
endtask

task automatic test_read_bounds();
   int lat;
   begin_test("read_bounds");
   issue_ar(32'(4 * 16), lat);   // One past the last word
   if (s_axil_rresp_o !== boot_pkg::SLVERR)
      note_mismatch(boot_pkg::SLVERR, s_axil_rresp_o);
   if (s_axil_rdata_o !== '0)
      note_mismatch(0, s_axil_rdata_o);
   take_r();
   issue_ar(32'(4 * 5), lat);    // Never written, still in range
   if (s_axil_rresp_o !== boot_pkg::OKAY)
      note_mismatch(boot_pkg::OKAY, s_axil_rresp_o);
   if (s_axil_rdata_o === boot_pkg::END_MARKER) begin
      $display("%s: end marker was stored at word 5", cur_test);
      test_err++;
   end
   take_r();
   end_test();
endtask

task automatic test_rready_stall();
   int          lat;
   logic [31:0] data0;
   logic [1:0]  resp0;
   begin_test("rready_stall");
   issue_ar(32'h8, lat);
   data0 = s_axil_rdata_o;
   resp0 = s_axil_rresp_o;
   if (data0 !== words[2])
      note_mismatch(words[2], data0);
   repeat (5) begin
      @(negedge clk);
      if (s_axil_rvalid_o !== 1'b1)
         note_mismatch(1, s_axil_rvalid_o);
      if (s_axil_rdata_o !== data0)
         note_mismatch(data0, s_axil_rdata_o);
      if (s_axil_rresp_o !== resp0)
         note_mismatch(resp0, s_axil_rresp_o);
      if (s_axil_arready_o !== 1'b0)
         note_mismatch(0, s_axil_arready_o);
   end
   take_r();
   if (s_axil_arready_o !== 1'b1)
      note_mismatch(1, s_axil_arready_o);
   if (s_axil_rvalid_o !== 1'b0)
      note_mismatch(0, s_axil_rvalid_o);
   end_test();
endtask

`endif

//--- tb_boot_top.sv
module tb_boot_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned DEPTH    = 16;
   localparam int unsigned BIT_CLKS = 8;      // Clocks per serial bit
   localparam int          TIMEOUT  = 2000;   // Cycles allowed for any wait

   logic                        clk = 1'b0;
   logic                        rst_n_i;
   logic                        uart_rx_i;
   logic [15:0]                 clks_per_bit_i;
   logic                        core_hold_o;
   logic                        s_axil_arvalid_i;
   logic                        s_axil_arready_o;
   logic [31:0]                 s_axil_araddr_i;
   logic                        s_axil_rvalid_o;
   logic                        s_axil_rready_i;
   logic [boot_pkg::DATA_W-1:0] s_axil_rdata_o;
   boot_pkg::axi_resp_e         s_axil_rresp_o;

   integer      seed;
   logic [31:0] words [5];   // Program image sent over the serial line
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          test_err;
   string       cur_test;

   always #5 clk = ~clk;

   boot_top #(.ICCM_DEPTH(DEPTH)) DUT (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .uart_rx_i        (uart_rx_i),
      .clks_per_bit_i   (clks_per_bit_i),
      .core_hold_o      (core_hold_o),
      .s_axil_arvalid_i (s_axil_arvalid_i),
      .s_axil_arready_o (s_axil_arready_o),
      .s_axil_araddr_i  (s_axil_araddr_i),
      .s_axil_rvalid_o  (s_axil_rvalid_o),
      .s_axil_rready_i  (s_axil_rready_i),
      .s_axil_rdata_o   (s_axil_rdata_o),
      .s_axil_rresp_o   (s_axil_rresp_o)
   );

   // ****************************************
   // Serial frame driver
   // ****************************************

   // 8N1 frame plus one idle bit so a bad stop bit still leaves an edge
   task automatic send_byte(input logic [7:0] b, input logic bad_stop);
      @(negedge clk);
      uart_rx_i = 1'b0;   // Start bit
      repeat (BIT_CLKS) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
         uart_rx_i = b[i];
         repeat (BIT_CLKS) @(negedge clk);
      end
      uart_rx_i = ~bad_stop;
      repeat (BIT_CLKS) @(negedge clk);
      uart_rx_i = 1'b1;   // Idle gap
      repeat (BIT_CLKS) @(negedge clk);
   endtask

   `include "tb_boot_tasks.svh"

   initial begin
      seed             = 32'h91b5;
      rst_n_i          = 1'b0;
      uart_rx_i        = 1'b1;
      clks_per_bit_i   = 16'(BIT_CLKS);
      s_axil_arvalid_i = 1'b0;
      s_axil_araddr_i  = '0;
      s_axil_rready_i  = 1'b0;
      repeat (4) @(negedge clk);
      rst_n_i = 1'b1;

      test_reset_state();
      test_read_while_loading();
      test_load_program();
      test_read_back();
      test_read_bounds();
      test_rready_stall();

      $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
boot_pkg.sv
uart_rx.sv
iccm_loader.sv
iccm_ram.sv
iccm_axil_rd.sv
boot_top.sv
tb_boot_top.sv
